// File: rtl/mac_kbd_pkg.sv
package mac_kbd_pkg;

	// PS/2 scan bytes, Mac command bytes and reply bytes
	typedef logic [7:0] byte_t;

	// One completed key from the scan decoder
	typedef struct packed {
		logic valid;
		logic brk;	// Release prefix seen
		logic extended;	// E0 prefix seen
		byte_t code;
	} key_event_t;

	typedef enum logic [2:0] {
		cmd_idle,
		cmd_instant,
		cmd_model,
		cmd_test,
		cmd_inq_hold,	// Inquiry before the short tick
		cmd_inq_open	// Inquiry waiting for a key or the long tick
	} cmd_state_e;

	// Mac host commands
	localparam byte_t CMD_INQUIRY = 8'h10;
	localparam byte_t CMD_INSTANT = 8'h14;
	localparam byte_t CMD_MODEL = 8'h16;
	localparam byte_t CMD_TEST = 8'h36;

	// Replies to the host
	localparam byte_t REPLY_MODEL = 8'h03;
	localparam byte_t REPLY_TEST = 8'h7d;
	localparam byte_t REPLY_NULL = 8'h7b;

	// PS/2 prefixes match on the upper seven bits only
	localparam byte_t SCAN_BREAK = 8'hf0;
	localparam byte_t SCAN_EXTEND = 8'he0;

endpackage

// File: rtl/scan_decoder.sv
module scan_decoder (
	input logic sysclk,
	input logic reset,
	input logic scan_strobe,
	input mac_kbd_pkg::byte_t scan_byte,
	output mac_kbd_pkg::key_event_t key_event
);

	logic brk_held;
	logic ext_held;
	logic is_break;
	logic is_extend;

	assign is_break = scan_byte[7:1] == mac_kbd_pkg::SCAN_BREAK[7:1];
	assign is_extend = scan_byte[7:1] == mac_kbd_pkg::SCAN_EXTEND[7:1];

	// Prefixes are held until the next plain byte closes the key
	always_ff @(posedge sysclk or posedge reset) begin
		if (reset) begin
			brk_held <= 1'b0;
			ext_held <= 1'b0;
			key_event <= '0;
		end else begin
			key_event.valid <= 1'b0;	// Single cycle event
			if (scan_strobe) begin
				if (is_break) begin
					brk_held <= 1'b1;
				end else if (is_extend) begin
					ext_held <= 1'b1;
				end else begin
					key_event.valid <= 1'b1;
					key_event.brk <= brk_held;
					key_event.extended <= ext_held;
					key_event.code <= scan_byte;
					brk_held <= 1'b0;
					ext_held <= 1'b0;
				end
			end
		end
	end

	// PS/2 bytes are far apart, so a key event never repeats on the next cycle
	a_event_single : assert property (
		@(posedge sysclk) disable iff (reset)
		key_event.valid |=> !key_event.valid
	);

endmodule

// File: rtl/key_buffer.sv
module key_buffer (
	input logic sysclk,
	input logic reset,
	input mac_kbd_pkg::key_event_t key_event,
	input logic key_take,
	output logic key_pending,
	output mac_kbd_pkg::byte_t key_code
);

	mac_kbd_pkg::byte_t mapped;

	// Scan code set 2 to Mac transition code with bit 0 set
	function automatic mac_kbd_pkg::byte_t map_key(input logic ext,
			input mac_kbd_pkg::byte_t code);
		mac_kbd_pkg::byte_t mac;
		case ({ext, code})
			9'h01c: mac = 8'h01;	// Letters a to z
			9'h032: mac = 8'h17;
			9'h021: mac = 8'h11;
			9'h023: mac = 8'h05;
			9'h024: mac = 8'h1d;
			9'h02b: mac = 8'h07;
			9'h034: mac = 8'h0b;
			9'h033: mac = 8'h09;
			9'h043: mac = 8'h45;
			9'h03b: mac = 8'h4d;
			9'h042: mac = 8'h51;
			9'h04b: mac = 8'h4b;
			9'h03a: mac = 8'h5d;
			9'h031: mac = 8'h5b;
			9'h044: mac = 8'h3f;
			9'h04d: mac = 8'h47;
			9'h015: mac = 8'h19;
			9'h02d: mac = 8'h1f;
			9'h01b: mac = 8'h03;
			9'h02c: mac = 8'h23;
			9'h03c: mac = 8'h41;
			9'h02a: mac = 8'h13;
			9'h01d: mac = 8'h1b;
			9'h022: mac = 8'h0f;
			9'h035: mac = 8'h21;
			9'h01a: mac = 8'h0d;
			9'h045: mac = 8'h3b;	// Digits 0 to 9
			9'h016: mac = 8'h25;
			9'h01e: mac = 8'h27;
			9'h026: mac = 8'h29;
			9'h025: mac = 8'h2b;
			9'h02e: mac = 8'h2f;
			9'h036: mac = 8'h2d;
			9'h03d: mac = 8'h35;
			9'h03e: mac = 8'h39;
			9'h046: mac = 8'h33;
			9'h029: mac = 8'h63;	// Space
			9'h05a: mac = 8'h49;	// Enter
			9'h066: mac = 8'h67;	// Backspace
			9'h00d: mac = 8'h61;	// Tab
			9'h076: mac = 8'h00;	// Escape has no Mac Plus key
			9'h012: mac = 8'h71;	// Left shift
			9'h059: mac = 8'h71;	// Right shift
			9'h011: mac = 8'h75;	// Left alt as option
			9'h111: mac = 8'h75;	// Right alt
			9'h014: mac = 8'h6f;	// Ctrl as command
			9'h11f: mac = 8'h6f;	// Left GUI
			9'h127: mac = 8'h6f;	// Right GUI
			9'h041: mac = 8'h57;	// Comma
			9'h049: mac = 8'h5f;
			9'h04a: mac = 8'h59;
			9'h04c: mac = 8'h53;
			9'h04e: mac = 8'h37;
			9'h055: mac = 8'h31;
			default: mac = mac_kbd_pkg::REPLY_NULL;
		endcase
		return mac;
	endfunction

	assign mapped = map_key(key_event.extended, key_event.code);

	// Only the first key is kept, later ones are lost until the host takes it
	always_ff @(posedge sysclk or posedge reset) begin
		if (reset) begin
			key_pending <= 1'b0;
		end else if (key_take) begin
			key_pending <= 1'b0;
		end else if (key_event.valid && !key_pending) begin
			key_pending <= 1'b1;
		end
	end

	always_ff @(posedge sysclk) begin
		if (key_event.valid && !key_pending && !key_take) begin
			key_code <= {key_event.brk, mapped[6:0]};	// Bit 7 marks a release
		end
	end

	// The host must see the same code for as long as the key waits
	a_code_stable : assert property (
		@(posedge sysclk) disable iff (reset)
		key_pending |=> !key_pending || $stable(key_code)
	);

endmodule

// File: rtl/pace_timer.sv
module pace_timer #(
	parameter int unsigned SHORT_TICKS = 4095,
	parameter int unsigned LONG_TICKS = 4194303
) (
	input logic sysclk,
	input logic reset,
	input logic cmd_strobe,
	output logic tick_short,
	output logic tick_long
);

	localparam int CNT_W = $clog2(LONG_TICKS + 1);

	logic [CNT_W-1:0] count;

	// Restarts on every host command, then parks at the long limit
	always_ff @(posedge sysclk or posedge reset) begin
		if (reset) begin
			count <= '0;
		end else if (cmd_strobe) begin
			count <= '0;
		end else if (!tick_long) begin
			count <= count + 1'b1;
		end
	end

	assign tick_short = count == CNT_W'(SHORT_TICKS);
	assign tick_long = count == CNT_W'(LONG_TICKS);	// Held until next command

	a_ticks_apart : assert property (
		@(posedge sysclk) disable iff (reset)
		!(tick_short && tick_long)
	);

endmodule

// File: rtl/mac_cmd_fsm.sv
module mac_cmd_fsm (
	input logic sysclk,
	input logic reset,
	input logic cmd_strobe,
	input mac_kbd_pkg::byte_t cmd_byte,
	input logic tick_short,
	input logic tick_long,
	input logic key_pending,
	input mac_kbd_pkg::byte_t key_code,
	output logic key_take,
	output logic reply_strobe,
	output mac_kbd_pkg::byte_t reply_byte
);

	mac_kbd_pkg::cmd_state_e state;
	mac_kbd_pkg::cmd_state_e state_next;

	// A new command always wins over any reply in flight
	always_comb begin
		state_next = state;
		if (cmd_strobe) begin
			case (cmd_byte)
				mac_kbd_pkg::CMD_INQUIRY: state_next = mac_kbd_pkg::cmd_inq_hold;
				mac_kbd_pkg::CMD_INSTANT: state_next = mac_kbd_pkg::cmd_instant;
				mac_kbd_pkg::CMD_MODEL: state_next = mac_kbd_pkg::cmd_model;
				mac_kbd_pkg::CMD_TEST: state_next = mac_kbd_pkg::cmd_test;
				default: state_next = mac_kbd_pkg::cmd_idle;	// Unknown command
			endcase
		end else if (reply_strobe) begin
			state_next = mac_kbd_pkg::cmd_idle;
		end else if (state == mac_kbd_pkg::cmd_inq_hold && tick_short) begin
			state_next = mac_kbd_pkg::cmd_inq_open;
		end
	end

	always_ff @(posedge sysclk or posedge reset) begin
		if (reset) begin
			state <= mac_kbd_pkg::cmd_idle;
		end else begin
			state <= state_next;
		end
	end

	// Reply timing from the pace ticks
	always_comb begin
		case (state)
			mac_kbd_pkg::cmd_instant,
			mac_kbd_pkg::cmd_model,
			mac_kbd_pkg::cmd_test: reply_strobe = tick_short;
			mac_kbd_pkg::cmd_inq_open: reply_strobe = key_pending || tick_long;
			default: reply_strobe = 1'b0;
		endcase
	end

	always_comb begin
		case (state)
			mac_kbd_pkg::cmd_model: reply_byte = mac_kbd_pkg::REPLY_MODEL;
			mac_kbd_pkg::cmd_test: reply_byte = mac_kbd_pkg::REPLY_TEST;
			default: reply_byte = key_pending ? key_code : mac_kbd_pkg::REPLY_NULL;
		endcase
	end

	// Every reply consumes the pending key, if any
	assign key_take = reply_strobe;

	a_reply_busy : assert property (
		@(posedge sysclk) disable iff (reset)
		reply_strobe |-> state != mac_kbd_pkg::cmd_idle
	);

endmodule

// File: rtl/mac_kbd_top.sv
module mac_kbd_top #(
	parameter int unsigned SHORT_TICKS = 4095,
	parameter int unsigned LONG_TICKS = 4194303
) (
	input logic sysclk,
	input logic reset,
	input logic scan_strobe,
	input mac_kbd_pkg::byte_t scan_byte,
	input logic cmd_strobe,
	input mac_kbd_pkg::byte_t cmd_byte,
	output logic reply_strobe,
	output mac_kbd_pkg::byte_t reply_byte
);

	mac_kbd_pkg::key_event_t key_event;
	mac_kbd_pkg::byte_t key_code;
	logic key_pending;
	logic key_take;
	logic tick_short;
	logic tick_long;

	scan_decoder decoder_i (
		.sysclk(sysclk),
		.reset(reset),
		.scan_strobe(scan_strobe),
		.scan_byte(scan_byte),
		.key_event(key_event)
	);

	key_buffer buffer_i (
		.sysclk(sysclk),
		.reset(reset),
		.key_event(key_event),
		.key_take(key_take),
		.key_pending(key_pending),
		.key_code(key_code)
	);

	pace_timer #(
		.SHORT_TICKS(SHORT_TICKS),
		.LONG_TICKS(LONG_TICKS)
	) timer_i (
		.sysclk(sysclk),
		.reset(reset),
		.cmd_strobe(cmd_strobe),
		.tick_short(tick_short),
		.tick_long(tick_long)
	);

	mac_cmd_fsm fsm_i (
		.sysclk(sysclk),
		.reset(reset),
		.cmd_strobe(cmd_strobe),
		.cmd_byte(cmd_byte),
		.tick_short(tick_short),
		.tick_long(tick_long),
		.key_pending(key_pending),
		.key_code(key_code),
		.key_take(key_take),
		.reply_strobe(reply_strobe),
		.reply_byte(reply_byte)
	);

endmodule

// File: bench/mac_kbd_table.svh
`ifndef MAC_KBD_TABLE_SVH
`define MAC_KBD_TABLE_SVH

// Each row holds is_cmd, the scan or command byte, the expected reply, min and max cycles
// to the reply, the cycle in which a key is sent during the command (0 for none) and its byte
typedef struct packed {
	logic is_cmd;
	mac_kbd_pkg::byte_t data;
	mac_kbd_pkg::byte_t expected;
	int min_cycles;
	int max_cycles;
	int key_after;
	mac_kbd_pkg::byte_t key_byte;
} row_t;

localparam int NUM_ROWS = 22;

localparam row_t ROWS [NUM_ROWS] = '{
	'{1'b1, 8'h16, 8'h03, 14, 400, 0, 8'h00},	// Model
	'{1'b1, 8'h36, 8'h7d, 14, 400, 0, 8'h00},	// Test
	'{1'b1, 8'h14, 8'h7b, 14, 400, 0, 8'h00},	// Instant with nothing pending
	'{1'b0, 8'h1c, 8'h00, 0, 0, 0, 8'h00},	// Key a
	'{1'b1, 8'h14, 8'h01, 14, 400, 0, 8'h00},
	'{1'b0, 8'hf0, 8'h00, 0, 0, 0, 8'h00},	// Release of a
	'{1'b0, 8'h1c, 8'h00, 0, 0, 0, 8'h00},
	'{1'b1, 8'h14, 8'h81, 14, 400, 0, 8'h00},
	'{1'b0, 8'he0, 8'h00, 0, 0, 0, 8'h00},	// Right alt
	'{1'b0, 8'h11, 8'h00, 0, 0, 0, 8'h00},
	'{1'b1, 8'h14, 8'h75, 14, 400, 0, 8'h00},
	'{1'b0, 8'he0, 8'h00, 0, 0, 0, 8'h00},	// Left GUI
	'{1'b0, 8'h1f, 8'h00, 0, 0, 0, 8'h00},
	'{1'b1, 8'h14, 8'h6f, 14, 400, 0, 8'h00},
	'{1'b0, 8'h05, 8'h00, 0, 0, 0, 8'h00},	// F1 has no Mac code
	'{1'b1, 8'h14, 8'h7b, 14, 400, 0, 8'h00},
	'{1'b1, 8'h10, 8'h7b, 291, 400, 0, 8'h00},	// Inquiry ends at the long tick
	'{1'b1, 8'h10, 8'h01, 21, 25, 20, 8'h1c},	// Key typed while inquiry is open
	'{1'b0, 8'h15, 8'h00, 0, 0, 0, 8'h00},	// Key q is kept
	'{1'b0, 8'h1a, 8'h00, 0, 0, 0, 8'h00},	// Key z is lost
	'{1'b1, 8'h14, 8'h19, 14, 400, 0, 8'h00},
	'{1'b1, 8'h14, 8'h7b, 14, 400, 0, 8'h00}
};

`endif

// File: bench/mac_kbd_tb.sv
module mac_kbd_tb;

	`include "mac_kbd_table.svh"

	localparam int REPLY_TIMEOUT = 400;

	logic sysclk = 1'b0;
	logic reset;
	logic scan_strobe;
	mac_kbd_pkg::byte_t scan_byte;
	logic cmd_strobe;
	mac_kbd_pkg::byte_t cmd_byte;
	logic reply_strobe;
	mac_kbd_pkg::byte_t reply_byte;

	mac_kbd_top #(
		.SHORT_TICKS(16),
		.LONG_TICKS(300)
	) dut_i (
		.sysclk(sysclk),
		.reset(reset),
		.scan_strobe(scan_strobe),
		.scan_byte(scan_byte),
		.cmd_strobe(cmd_strobe),
		.cmd_byte(cmd_byte),
		.reply_strobe(reply_strobe),
		.reply_byte(reply_byte)
	);

	always #4 sysclk = ~sysclk;	// Period 8

	task automatic stop_with_error(input string what);
		$display("%s", what);
		$display("Test failures found");
		$fatal(1);
	endtask

	// Drive and sample just after the rising edge
	task automatic next_cycle();
		@(posedge sysclk);
		#1;
	endtask

	task automatic idle_cycle();
		next_cycle();
		scan_strobe = 1'b0;
		cmd_strobe = 1'b0;
		assert (!reply_strobe) else stop_with_error("Reply strobe seen with no command waiting");
	endtask

	// PS/2 bytes never arrive back to back
	task automatic send_scan(input mac_kbd_pkg::byte_t value);
		scan_byte = value;
		scan_strobe = 1'b1;
		idle_cycle();
		idle_cycle();
	endtask

	task automatic run_command(input row_t row);
		int cycles;
		cmd_byte = row.data;
		cmd_strobe = 1'b1;
		cycles = 0;
		do begin
			next_cycle();
			cycles++;
			cmd_strobe = 1'b0;
			scan_strobe = 1'b0;
			if (row.key_after != 0 && cycles == row.key_after) begin
				scan_byte = row.key_byte;	// Key typed while the host waits
				scan_strobe = 1'b1;
			end
		end while (!reply_strobe && cycles < REPLY_TIMEOUT);
		assert (reply_strobe) else stop_with_error($sformatf(
			"No reply to command %02h within %0d cycles", row.data, REPLY_TIMEOUT));
		assert (cycles >= row.min_cycles) else stop_with_error($sformatf(
			"Reply to command %02h came too early, after %0d cycles", row.data, cycles));
		assert (cycles <= row.max_cycles) else stop_with_error($sformatf(
			"Reply to command %02h came too late, after %0d cycles", row.data, cycles));
		assert (reply_byte == row.expected) else stop_with_error($sformatf(
			"Mismatch reply_byte: got %02h, expected %02h", reply_byte, row.expected));
	endtask

	initial begin
		int gap;
		reset = 1'b1;
		scan_strobe = 1'b0;
		scan_byte = '0;
		cmd_strobe = 1'b0;
		cmd_byte = '0;
		void'($urandom(32'hec40));
		repeat (3) @(posedge sysclk);
		#1;
		reset = 1'b0;
		for (int i = 0; i < NUM_ROWS; i++) begin
			if (ROWS[i].is_cmd) begin
				run_command(ROWS[i]);
			end else begin
				send_scan(ROWS[i].data);
			end
			gap = $urandom_range(5, 0);
			repeat (gap) idle_cycle();
		end
		$display("All tests passed!");
		$finish;
	end

endmodule

// File: mac_kbd.f
+incdir+bench
rtl/mac_kbd_pkg.sv
rtl/scan_decoder.sv
rtl/key_buffer.sv
rtl/pace_timer.sv
rtl/mac_cmd_fsm.sv
rtl/mac_kbd_top.sv
bench/mac_kbd_tb.sv

// File: Makefile
LOG := sim.log

all: run

run:
	verilator --binary --timing --assert -f mac_kbd.f --top-module mac_kbd_tb -Mdir obj_dir
	./obj_dir/Vmac_kbd_tb > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "Test failures found" $(LOG); then exit 1; fi
	@grep -q "All tests passed!" $(LOG)

lint:
	verilator --lint-only --timing --assert -f mac_kbd.f --top-module mac_kbd_tb
	verilator --lint-only --assert rtl/mac_kbd_pkg.sv rtl/scan_decoder.sv rtl/key_buffer.sv \
		rtl/pace_timer.sv rtl/mac_cmd_fsm.sv rtl/mac_kbd_top.sv --top-module mac_kbd_top

clean:
	rm -rf obj_dir $(LOG)

.PHONY: all run lint clean
